// File: design/time_pkg.sv
package time_pkg;

    ////////////////////////////////////////////////////////////
    // time values, all in milliseconds
    ////////////////////////////////////////////////////////////

    localparam int time_w = 22;                // enough for 59:59.999

    typedef logic [time_w-1:0] ms_t;

    localparam ms_t ms_per_sec = ms_t'(1000);
    localparam ms_t ms_per_min = ms_t'(60000);

    // 59 min 59.999 s, the count and the preset both stop here
    localparam ms_t time_limit = ms_t'(3599999);

endpackage

// File: design/panel_pkg.sv
package panel_pkg;

    ////////////////////////////////////////////////////////////
    // operating mode, decoded from the p and u switches
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        mode_program = 2'd0,   // p high
        mode_up      = 2'd1,   // p low, u high
        mode_down    = 2'd2    // p low, u low
    } mode_t;

    ////////////////////////////////////////////////////////////
    // command pulses between the blocks
    ////////////////////////////////////////////////////////////

    // panel control to preset store, one-cycle pulses
    typedef struct packed {
        logic add_min;   // inc with min high
        logic add_sec;   // inc with min low
        logic clear;     // rst in program mode
    } prog_cmd_t;

    // panel control to time counter
    typedef struct packed {
        logic load;      // copy the preset into t
        logic clear;     // force t to zero
        logic tick;      // one millisecond step
        logic down;      // step direction, level
    } count_cmd_t;

endpackage

// File: design/panel_control.sv
`timescale 1ns/1ps

module panel_control #(
    parameter int unsigned ticks_per_ms = 100000
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  p,
    input  logic                  u,
    input  logic                  min,
    input  logic                  s,
    input  logic                  rst,
    input  logic                  inc,
    output panel_pkg::prog_cmd_t  prog_cmd,
    output panel_pkg::count_cmd_t count_cmd
);

    localparam int cnt_w = (ticks_per_ms > 1) ? $clog2(ticks_per_ms) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(ticks_per_ms - 1);

    logic s_q;
    logic rst_q;
    logic inc_q;
    logic s_rise;
    logic rst_rise;
    logic inc_rise;

    panel_pkg::mode_t mode_now;
    panel_pkg::mode_t mode_q;
    logic             mode_chg;
    logic             in_prog;
    logic             in_up;
    logic             in_down;

    logic             run_q;
    logic             run_next;
    logic [cnt_w-1:0] pre_cnt;
    logic             tick;

    ////////////////////////////////////////////////////////////
    // button edges
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s_q   <= 1'b0;
            rst_q <= 1'b0;
            inc_q <= 1'b0;
        end else begin
            s_q   <= s;
            rst_q <= rst;
            inc_q <= inc;
        end
    end

    assign s_rise   = s & ~s_q;
    assign rst_rise = rst & ~rst_q;
    assign inc_rise = inc & ~inc_q;

    ////////////////////////////////////////////////////////////
    // mode and run state
    ////////////////////////////////////////////////////////////

    // p wins over u
    assign mode_now = p ? panel_pkg::mode_program
                        : (u ? panel_pkg::mode_up : panel_pkg::mode_down);

    assign mode_chg = (mode_now != mode_q);
    assign in_prog  = (mode_now == panel_pkg::mode_program);
    assign in_up    = (mode_now == panel_pkg::mode_up);
    assign in_down  = (mode_now == panel_pkg::mode_down);

    always_comb begin
        run_next = run_q;
        if (mode_chg || rst_rise || in_prog) begin
            run_next = 1'b0;             // any mode change or rst stops the watch
        end else if (s_rise) begin
            run_next = ~run_q;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode_q <= panel_pkg::mode_up;   // so entering down mode loads the preset
            run_q  <= 1'b0;
        end else begin
            mode_q <= mode_now;
            run_q  <= run_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // millisecond prescaler
    ////////////////////////////////////////////////////////////

    assign tick = run_q && (pre_cnt == cnt_last);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pre_cnt <= '0;
        end else if (!run_q || tick) begin
            pre_cnt <= '0;                  // held at zero while stopped
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // commands
    ////////////////////////////////////////////////////////////

    always_comb begin
        prog_cmd.add_min = in_prog && inc_rise && min;
        prog_cmd.add_sec = in_prog && inc_rise && !min;
        prog_cmd.clear   = in_prog && rst_rise;

        // t follows the preset all through program mode
        count_cmd.load  = in_prog || (in_down && (mode_chg || rst_rise));
        count_cmd.clear = in_up && (rst_rise || mode_chg);
        count_cmd.tick  = tick;
        count_cmd.down  = (mode_q == panel_pkg::mode_down);
    end

endmodule

// File: design/preset_store.sv
`timescale 1ns/1ps

module preset_store (
    input  logic                 clk,
    input  logic                 arst_n,
    input  panel_pkg::prog_cmd_t prog_cmd,
    output time_pkg::ms_t        preset
);

    time_pkg::ms_t             step;
    logic [time_pkg::time_w:0] sum;     // one spare bit for the carry
    time_pkg::ms_t             preset_next;

    assign step = prog_cmd.add_min ? time_pkg::ms_per_min : time_pkg::ms_per_sec;
    assign sum  = {1'b0, preset} + {1'b0, step};

    always_comb begin
        preset_next = preset;
        if (prog_cmd.clear) begin
            preset_next = '0;
        end else if (prog_cmd.add_min || prog_cmd.add_sec) begin
            if (sum > {1'b0, time_pkg::time_limit}) begin
                preset_next = time_pkg::time_limit;    // saturate at 59:59.999
            end else begin
                preset_next = sum[time_pkg::time_w-1:0];
            end
        end
    end

    // kept across mode changes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            preset <= '0;
        end else begin
            preset <= preset_next;
        end
    end

endmodule

// File: design/time_counter.sv
`timescale 1ns/1ps

module time_counter (
    input  logic                  clk,
    input  logic                  arst_n,
    input  panel_pkg::count_cmd_t count_cmd,
    input  time_pkg::ms_t         preset,
    output time_pkg::ms_t         t,
    output logic                  zero
);

    time_pkg::ms_t t_next;
    logic          at_zero;
    logic          at_limit;

    assign at_zero  = (t == '0);
    assign at_limit = (t >= time_pkg::time_limit);

    ////////////////////////////////////////////////////////////
    // next displayed time
    ////////////////////////////////////////////////////////////

    always_comb begin
        t_next = t;
        if (count_cmd.clear) begin
            t_next = '0;
        end else if (count_cmd.load) begin
            t_next = preset;
        end else if (count_cmd.tick) begin
            if (count_cmd.down) begin
                if (!at_zero) begin
                    t_next = t - 1'b1;              // stops at zero
                end
            end else if (!at_limit) begin
                t_next = t + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // time and zero flag, updated together
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            t    <= '0;
            zero <= 1'b1;
        end else begin
            t    <= t_next;
            zero <= (t_next == '0);   // from next value, no extra cycle
        end
    end

endmodule

// File: design/stopwatch_top.sv
`timescale 1ns/1ps

module stopwatch_top #(
    parameter int unsigned ticks_per_ms = 100000
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          p,      // program switch
    input  logic          u,      // up/down switch
    input  logic          min,    // minute/second step select
    input  logic          s,      // start/stop button
    input  logic          rst,
    input  logic          inc,
    output time_pkg::ms_t t,
    output logic          zero
);

    panel_pkg::prog_cmd_t  prog_cmd;
    panel_pkg::count_cmd_t count_cmd;
    time_pkg::ms_t         preset;

    ////////////////////////////////////////////////////////////
    // buttons and switches to commands
    ////////////////////////////////////////////////////////////

    panel_control #(
        .ticks_per_ms (ticks_per_ms)
    ) panel_control0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .p         (p),
        .u         (u),
        .min       (min),
        .s         (s),
        .rst       (rst),
        .inc       (inc),
        .prog_cmd  (prog_cmd),
        .count_cmd (count_cmd)
    );

    // programmed limit
    preset_store preset_store0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .prog_cmd (prog_cmd),
        .preset   (preset)
    );

    // displayed time
    time_counter time_counter0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .count_cmd (count_cmd),
        .preset    (preset),
        .t         (t),
        .zero      (zero)
    );

endmodule

// File: tests/stopwatch_properties.sv
`timescale 1ns/1ps

module stopwatch_properties (
    input logic                  clk,
    input logic                  arst_n,
    input panel_pkg::count_cmd_t count_cmd,
    input time_pkg::ms_t         t,
    input logic                  zero
);

    int unsigned range_fails = 0;
    int unsigned zero_fails  = 0;
    int unsigned step_fails  = 0;

    logic plain_tick;   // a tick that neither clear nor load overrides

    assign plain_tick = count_cmd.tick && !count_cmd.clear && !count_cmd.load;

    ////////////////////////////////////////////////////////////
    // displayed time checks
    ////////////////////////////////////////////////////////////

    t_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        t <= time_pkg::time_limit)
    else begin
        range_fails++;
        $error("t is above time_limit");
    end

    // flag and time are registered on the same edge
    zero_matches_t: assert property (@(posedge clk) disable iff (!arst_n)
        zero == (t == '0))
    else begin
        zero_fails++;
        $error("zero does not match t");
    end

    tick_step_one: assert property (@(posedge clk) disable iff (!arst_n)
        plain_tick |=> (t == $past(t))
                    || (t == $past(t) + time_pkg::ms_t'(1))
                    || (t == $past(t) - time_pkg::ms_t'(1)))
    else begin
        step_fails++;
        $error("t moved by more than one on a tick");
    end

endmodule

bind time_counter stopwatch_properties props0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .count_cmd (count_cmd),
    .t         (t),
    .zero      (zero)
);

// File: tests/stopwatch_tb.sv
`timescale 1ns/1ps

module stopwatch_tb;

    localparam int unsigned ticks    = 4;            // clock cycles per millisecond
    localparam int unsigned seed     = 32'h1b63e748;
    localparam int unsigned ms_sec   = 1000;
    localparam int unsigned ms_min   = 60000;
    localparam int unsigned limit_ms = 3599999;      // 59:59.999

    localparam int unsigned btn_s   = 0;
    localparam int unsigned btn_rst = 1;
    localparam int unsigned btn_inc = 2;

    // cycle budgets per test, summed for the watchdog
    localparam int unsigned reset_budget = 20;
    localparam int unsigned up_budget    = 150;
    localparam int unsigned prog_budget  = 300;
    localparam int unsigned down_budget  = 1000 * ticks + 100;
    localparam int unsigned rerun_budget = 600;
    localparam int unsigned margin       = 200;
    localparam int unsigned watchdog_ns  = 10 * (reset_budget + up_budget + prog_budget
                                               + down_budget + rerun_budget + margin);

    logic          clk;
    logic          arst_n;
    logic          p;
    logic          u;
    logic          min;
    logic          s;
    logic          rst;
    logic          inc;
    time_pkg::ms_t t;
    logic          zero;

    int unsigned errors = 0;

    stopwatch_top #(
        .ticks_per_ms (ticks)
    ) dut0 (
        .clk    (clk),
        .arst_n (arst_n),
        .p      (p),
        .u      (u),
        .min    (min),
        .s      (s),
        .rst    (rst),
        .inc    (inc),
        .t      (t),
        .zero   (zero)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input int unsigned expected,
                               input int unsigned actual);
        assert (actual == expected) else begin
            errors++;
            $display("Error: %0t %s expected %0d got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_time(input int unsigned expected);
        check_value("t", expected, 32'(t));
        check_value("zero", (expected == 0) ? 1 : 0, 32'(zero));
    endtask

    task automatic idle(input int unsigned n);
        repeat (n) @(negedge clk);
    endtask

    // one cycle high, sampled on the next rising edge
    task automatic press(input int unsigned btn);
        case (btn)
            btn_s:   s = 1'b1;
            btn_rst: rst = 1'b1;
            default: inc = 1'b1;
        endcase
        @(negedge clk);
        s   = 1'b0;
        rst = 1'b0;
        inc = 1'b0;
    endtask

    task automatic check_hold(input int unsigned n, input int unsigned expected);
        repeat (n) begin
            @(negedge clk);
            check_time(expected);
        end
    endtask

    function automatic int unsigned add_step(input int unsigned cur, input int unsigned step);
        return (cur + step > limit_ms) ? limit_ms : cur + step;
    endfunction

    function automatic int unsigned property_fails();
        return dut0.time_counter0.props0.range_fails
             + dut0.time_counter0.props0.zero_fails
             + dut0.time_counter0.props0.step_fails;
    endfunction

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset();
        check_time(0);
        check_hold(8, 0);                // up mode, nothing pressed
    endtask

    task automatic test_count_up();
        int unsigned run_len;
        int unsigned pause;
        int unsigned expected;
        run_len = 10 + $urandom % 50;
        pause   = 5 + $urandom % 30;
        press(btn_s);                    // run high from this edge
        idle(run_len);
        press(btn_s);                    // stop edge is run_len + 1 edges later
        expected = (run_len + 1) / ticks;
        check_time(expected);
        check_hold(pause, expected);
    endtask

    task automatic test_programming();
        int unsigned n_min;
        int unsigned n_sec;
        int unsigned expected;
        n_min    = 1 + $urandom % 5;
        n_sec    = 1 + $urandom % 20;
        expected = 0;
        p = 1'b1;
        idle(2);
        check_time(0);
        min = 1'b1;
        repeat (n_min) begin
            press(btn_inc);
            idle(1);                     // t follows the preset one cycle later
            expected = add_step(expected, ms_min);
        end
        min = 1'b0;
        repeat (n_sec) begin
            press(btn_inc);
            idle(1);
            expected = add_step(expected, ms_sec);
        end
        check_time(expected);
        // push past the hour to reach the cap
        min = 1'b1;
        repeat (61) begin
            press(btn_inc);
            idle(1);
            expected = add_step(expected, ms_min);
        end
        check_time(expected);
        check_value("t at cap", limit_ms, 32'(t));
        press(btn_rst);
        idle(1);
        check_time(0);
    endtask

    task automatic test_count_down();
        int unsigned cycles;
        min = 1'b0;
        press(btn_inc);
        idle(1);
        check_time(ms_sec);
        p = 1'b0;
        u = 1'b0;
        idle(1);                         // entering down mode loads the preset
        check_time(ms_sec);
        press(btn_s);
        cycles = 0;
        while (!zero && cycles < 1000 * ticks + 50) begin
            @(negedge clk);
            cycles++;
        end
        assert (zero) else begin
            errors++;
            $display("Error: %0t the count down never reached zero", $time);
        end
        check_value("cycles to zero", 1000 * ticks, cycles);
        check_time(0);
        check_hold(20, 0);               // still running, stuck at zero
    endtask

    task automatic test_reset_in_run();
        int unsigned run_len;
        int unsigned pause;
        // leave down mode and come back for a fresh load
        u = 1'b1;
        idle(1);
        check_time(0);
        u = 1'b0;
        idle(1);
        check_time(ms_sec);
        run_len = 20 + $urandom % 200;
        pause   = 5 + $urandom % 30;
        press(btn_s);
        idle(run_len);
        check_time(ms_sec - run_len / ticks);
        press(btn_rst);
        // rst in down mode reloads the preset and stops the count
        check_time(ms_sec);
        check_hold(pause, ms_sec);

        u = 1'b1;
        idle(1);
        check_time(0);
        run_len = 20 + $urandom % 200;
        press(btn_s);
        idle(run_len);
        check_time(run_len / ticks);
        press(btn_rst);
        check_time(0);
        check_hold(pause, 0);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        int unsigned total;
        void'($urandom(seed));
        arst_n = 1'b0;
        p      = 1'b0;
        u      = 1'b1;
        min    = 1'b0;
        s      = 1'b0;
        rst    = 1'b0;
        inc    = 1'b0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        test_reset();
        test_count_up();
        test_programming();
        test_count_down();
        test_reset_in_run();
        total = errors + property_fails();
        $display("errors: %0d (checks %0d, assertions %0d)", total, errors, property_fails());
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("errors: %0d (checks %0d, assertions %0d)",
                 errors + property_fails(), errors, property_fails());
        $display("Errors found");
        $finish;
    end

endmodule

// File: list.f
design/time_pkg.sv
design/panel_pkg.sv
design/panel_control.sv
design/preset_store.sv
design/time_counter.sv
design/stopwatch_top.sv
tests/stopwatch_properties.sv
tests/stopwatch_tb.sv

// File: Makefile
# Verilator build and run for the stopwatch testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = stopwatch_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = No errors
RUN_OPTS  = +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_OPTS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then echo "test passed"; \
	else echo "test failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
